/* iis_pkg.sv */
// Shared widths and vector types for the I2S loopback project
// Modules refer to these by scoped names; top-level parameters default to them
package iis_pkg;

  // ADC test word width, as produced by the codec model
  localparam int unsigned DEF_DATA_SIZE = 16;

  // DAC sample width, as sent by the handler
  localparam int unsigned DEF_DATA_SIZE_FIR_OUT = 32;

  // BCLK periods per half-frame
  // One delay bit, the 32-bit sample, then one spare bit
  localparam int unsigned DEF_SLOT_BITS = 34;

  // clk_i cycles per BCLK half-period
  localparam int unsigned DEF_BCLK_DIV = 4;

  // Sample carried on the DAC line
  typedef logic [DEF_DATA_SIZE_FIR_OUT-1:0] dac_sample_t;

  // Word carried on the ADC line
  typedef logic [DEF_DATA_SIZE-1:0] adc_sample_t;

  // Bit position within one LRCLK slot
  // Position 0 is the delay bit after the LRCLK edge
  typedef logic [7:0] bit_cnt_t;

endpackage

/* iis_clock_gen.sv */
// I2S master clocking from clk_i: MCLK, BCLK and LRCLK levels plus edge strobes
// Each strobe is registered with the level change it marks, so both share a cycle
`timescale 1ns/1ns

module iis_clock_gen #(
  parameter int unsigned BCLK_DIV  = iis_pkg::DEF_BCLK_DIV,
  parameter int unsigned SLOT_BITS = iis_pkg::DEF_SLOT_BITS
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic mclk,
  output logic bclk,
  output logic lrclk,        // Low for left slot, high for right slot
  output logic bclk_rise,
  output logic bclk_fall,
  output logic frame_start   // Marks the LRCLK falling edge
);

  localparam int unsigned DIV_W  = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
  localparam int unsigned SLOT_W = (SLOT_BITS > 1) ? $clog2(SLOT_BITS) : 1;

  logic [DIV_W-1:0]  div_cnt;    // clk_i cycles in the current BCLK half
  logic [SLOT_W-1:0] slot_cnt;   // BCLK periods in the current slot
  logic              half_end;
  logic              slot_end;

  assign half_end = (div_cnt == DIV_W'(BCLK_DIV - 1));
  assign slot_end = (slot_cnt == SLOT_W'(SLOT_BITS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mclk        <= 1'b0;
      bclk        <= 1'b0;
      lrclk       <= 1'b0;
      bclk_rise   <= 1'b0;
      bclk_fall   <= 1'b0;
      frame_start <= 1'b0;
      div_cnt     <= '0;
      slot_cnt    <= '0;
    end else begin
      mclk        <= ~mclk;
      bclk_rise   <= half_end && !bclk;
      bclk_fall   <= half_end && bclk;
      frame_start <= half_end && bclk && slot_end && lrclk;
      if (half_end) begin
        div_cnt <= '0;
        bclk    <= ~bclk;
        // A falling edge closes one BCLK period
        if (bclk) begin
          if (slot_end) begin
            slot_cnt <= '0;
            lrclk    <= ~lrclk;   // Slot boundary on the same falling edge
          end else begin
            slot_cnt <= slot_cnt + 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

/* iis_transmitter.sv */
// I2S transmitter: takes a left/right pair at frame start, shifts it MSB first
// onto the DAC line, one delay bit after each LRCLK edge, zero padded to the slot end
`timescale 1ns/1ns

module iis_transmitter #(
  parameter int unsigned DATA_SIZE_FIR_OUT = iis_pkg::DEF_DATA_SIZE_FIR_OUT,
  parameter int unsigned SLOT_BITS         = iis_pkg::DEF_SLOT_BITS
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         bclk_fall,
  input  logic                         lrclk,
  input  logic                         frame_start,
  input  logic [DATA_SIZE_FIR_OUT-1:0] tx_left,
  input  logic [DATA_SIZE_FIR_OUT-1:0] tx_right,
  output logic                         tx_load,
  output logic                         dac_sdata
);

  localparam iis_pkg::bit_cnt_t LAST_POS  = iis_pkg::bit_cnt_t'(SLOT_BITS - 1);
  localparam iis_pkg::bit_cnt_t DATA_BITS = iis_pkg::bit_cnt_t'(DATA_SIZE_FIR_OUT);

  logic [DATA_SIZE_FIR_OUT-1:0] shift_q;
  logic [DATA_SIZE_FIR_OUT-1:0] right_q;   // Right sample waits out the left slot
  iis_pkg::bit_cnt_t            bit_cnt;
  logic                         lr_prev;   // lrclk as seen at the previous BCLK fall
  logic                         right_start;

  // lrclk only moves on bclk_fall cycles, so this marks the left-to-right edge
  assign right_start = bclk_fall && lrclk && !lr_prev;

  // Sample pair is taken in the frame_start cycle itself
  assign tx_load = frame_start;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lr_prev   <= 1'b0;
      bit_cnt   <= '0;
      shift_q   <= '0;
      right_q   <= '0;
      dac_sdata <= 1'b0;
    end else begin
      if (bclk_fall) lr_prev <= lrclk;

      if (frame_start) begin
        shift_q   <= tx_left;
        right_q   <= tx_right;
        bit_cnt   <= '0;
        dac_sdata <= 1'b0;   // Delay bit
      end else if (right_start) begin
        shift_q   <= right_q;
        bit_cnt   <= '0;
        dac_sdata <= 1'b0;
      end else if (bclk_fall) begin
        if (bit_cnt != LAST_POS) bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < DATA_BITS) begin
          dac_sdata <= shift_q[DATA_SIZE_FIR_OUT-1];
          shift_q   <= {shift_q[DATA_SIZE_FIR_OUT-2:0], 1'b0};
        end else begin
          dac_sdata <= 1'b0;   // Padding up to the slot end
        end
      end
    end
  end

endmodule

/* iis_receiver.sv */
// I2S receiver: samples the ADC line on BCLK rising edges, bit positions 1 to DATA_SIZE
// The left word is parked at the slot change, both words come out with rx_valid
`timescale 1ns/1ns

module iis_receiver #(
  parameter int unsigned DATA_SIZE = iis_pkg::DEF_DATA_SIZE,
  parameter int unsigned SLOT_BITS = iis_pkg::DEF_SLOT_BITS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 bclk_rise,
  input  logic                 lrclk,
  input  logic                 frame_start,
  input  logic                 adc_sdata,
  output logic [DATA_SIZE-1:0] rx_left,
  output logic [DATA_SIZE-1:0] rx_right,
  output logic                 rx_valid
);

  localparam iis_pkg::bit_cnt_t LAST_POS  = iis_pkg::bit_cnt_t'(SLOT_BITS - 1);
  localparam iis_pkg::bit_cnt_t DATA_BITS = iis_pkg::bit_cnt_t'(DATA_SIZE);

  logic [DATA_SIZE-1:0] shift_q;
  logic [DATA_SIZE-1:0] left_q;      // Finished left word, held through the right slot
  iis_pkg::bit_cnt_t    bit_cnt;
  logic                 lr_q;
  logic                 slot_edge;
  logic                 in_window;

  assign slot_edge = (lrclk != lr_q);

  // Position 0 is the delay bit, padding after DATA_SIZE is dropped
  assign in_window = (bit_cnt != '0) && (bit_cnt <= DATA_BITS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lr_q     <= 1'b0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      lr_q     <= lrclk;
      rx_valid <= frame_start;   // Right slot has just closed
      if (slot_edge) begin
        bit_cnt <= '0;
      end else if (bclk_rise && (bit_cnt != LAST_POS)) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Data path
  always_ff @(posedge clk_i) begin
    if (bclk_rise && in_window) begin
      shift_q <= {shift_q[DATA_SIZE-2:0], adc_sdata};
    end

    if (slot_edge && lrclk) left_q <= shift_q;   // Left slot ends

    if (frame_start) begin
      rx_left  <= left_q;
      rx_right <= shift_q;
    end
  end

endmodule

/* iis_dummy_device.sv */
// Codec stand-in for the I2S handler, watching the clock lines as sampled levels
// Shows the last DAC word per slot and sends test_data_in on the ADC line every slot
`timescale 1ns/1ns

module iis_dummy_device #(
  parameter int unsigned DATA_SIZE         = iis_pkg::DEF_DATA_SIZE,
  parameter int unsigned DATA_SIZE_FIR_OUT = iis_pkg::DEF_DATA_SIZE_FIR_OUT
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ac_mclk,        // Codec master clock
  input  logic                         ac_bclk,        // Bit clock
  input  logic                         ac_lrclk,       // Left/right clock
  input  logic                         ac_dac_sdata,   // Serial data from the handler
  input  logic [DATA_SIZE-1:0]         test_data_in,   // Word returned in every slot
  output logic                         ac_adc_sdata,   // Serial data to the handler
  output logic [DATA_SIZE_FIR_OUT-1:0] test_data_out   // Last word received
);

  localparam iis_pkg::bit_cnt_t DATA_BITS = iis_pkg::bit_cnt_t'(DATA_SIZE_FIR_OUT);

  logic lr_last;
  logic bclk_last;
  logic mclk_last;
  logic lr_edge;       // Either LRCLK edge
  logic bclk_rise_q;
  logic bclk_fall_q;
  logic mclk_run;      // MCLK seen toggling

  logic [DATA_SIZE_FIR_OUT-1:0] rx_shift;
  iis_pkg::bit_cnt_t            rise_cnt;
  logic [DATA_SIZE:0]           tx_shift;   // Extra MSB is the delay bit

  // Edge detectors, each pulse one cycle after the level moves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lr_last     <= 1'b0;
      bclk_last   <= 1'b0;
      mclk_last   <= 1'b0;
      lr_edge     <= 1'b0;
      bclk_rise_q <= 1'b0;
      bclk_fall_q <= 1'b0;
      mclk_run    <= 1'b0;
    end else begin
      lr_last     <= ac_lrclk;
      bclk_last   <= ac_bclk;
      mclk_last   <= ac_mclk;
      lr_edge     <= lr_last ^ ac_lrclk;
      bclk_rise_q <= !bclk_last && ac_bclk;
      bclk_fall_q <= bclk_last && !ac_bclk;
      mclk_run    <= mclk_last ^ ac_mclk;
    end
  end

  // Shift in DAC bits 1..DATA_SIZE_FIR_OUT of each slot
  // The word is published at the LRCLK edge that closes the slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      test_data_out <= '0;
      rx_shift      <= '0;
      rise_cnt      <= '0;
    end else if (lr_edge) begin
      test_data_out <= rx_shift;
      rx_shift      <= '0;
      rise_cnt      <= '0;
    end else if (bclk_rise_q) begin
      if (rise_cnt != '1) rise_cnt <= rise_cnt + 1'b1;
      if ((rise_cnt != '0) && (rise_cnt <= DATA_BITS)) begin
        rx_shift <= {rx_shift[DATA_SIZE_FIR_OUT-2:0], ac_dac_sdata};
      end
    end
  end

  // Shift out the test word, leading zero covers the delay bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_shift <= '0;
    end else if (lr_edge) begin
      tx_shift <= {1'b0, test_data_in};
    end else if (bclk_fall_q) begin
      tx_shift <= {tx_shift[DATA_SIZE-1:0], 1'b0};
    end
  end

  // No ADC output without a running master clock
  assign ac_adc_sdata = tx_shift[DATA_SIZE] & mclk_run;

endmodule

/* iis_loopback_top.sv */
// I2S loopback: host-side handler (clocking, transmit, receive) wired to the codec model
// All blocks run on clk_i; parameters are set here and passed down
`timescale 1ns/1ns

module iis_loopback_top #(
  parameter int unsigned DATA_SIZE         = iis_pkg::DEF_DATA_SIZE,
  parameter int unsigned DATA_SIZE_FIR_OUT = iis_pkg::DEF_DATA_SIZE_FIR_OUT,
  parameter int unsigned SLOT_BITS         = iis_pkg::DEF_SLOT_BITS,
  parameter int unsigned BCLK_DIV          = iis_pkg::DEF_BCLK_DIV
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  iis_pkg::dac_sample_t tx_left,
  input  iis_pkg::dac_sample_t tx_right,
  input  iis_pkg::adc_sample_t codec_data_in,
  output logic                 tx_load,
  output iis_pkg::adc_sample_t rx_left,
  output iis_pkg::adc_sample_t rx_right,
  output logic                 rx_valid,
  output iis_pkg::dac_sample_t codec_data_out,
  output logic                 lrclk
);

  logic mclk;
  logic bclk;
  logic bclk_rise;
  logic bclk_fall;
  logic frame_start;
  logic dac_sdata;   // Handler to codec
  logic adc_sdata;   // Codec to handler

  iis_clock_gen #(
    .BCLK_DIV  (BCLK_DIV),
    .SLOT_BITS (SLOT_BITS)
  ) u_clock_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mclk        (mclk),
    .bclk        (bclk),
    .lrclk       (lrclk),
    .bclk_rise   (bclk_rise),
    .bclk_fall   (bclk_fall),
    .frame_start (frame_start)
  );

  iis_transmitter #(
    .DATA_SIZE_FIR_OUT (DATA_SIZE_FIR_OUT),
    .SLOT_BITS         (SLOT_BITS)
  ) u_transmitter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bclk_fall   (bclk_fall),
    .lrclk       (lrclk),
    .frame_start (frame_start),
    .tx_left     (tx_left),
    .tx_right    (tx_right),
    .tx_load     (tx_load),
    .dac_sdata   (dac_sdata)
  );

  iis_receiver #(
    .DATA_SIZE (DATA_SIZE),
    .SLOT_BITS (SLOT_BITS)
  ) u_receiver (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bclk_rise   (bclk_rise),
    .lrclk       (lrclk),
    .frame_start (frame_start),
    .adc_sdata   (adc_sdata),
    .rx_left     (rx_left),
    .rx_right    (rx_right),
    .rx_valid    (rx_valid)
  );

  // Codec model sees only the clock levels
  iis_dummy_device #(
    .DATA_SIZE         (DATA_SIZE),
    .DATA_SIZE_FIR_OUT (DATA_SIZE_FIR_OUT)
  ) u_codec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ac_mclk       (mclk),
    .ac_bclk       (bclk),
    .ac_lrclk      (lrclk),
    .ac_dac_sdata  (dac_sdata),
    .test_data_in  (codec_data_in),
    .ac_adc_sdata  (adc_sdata),
    .test_data_out (codec_data_out)
  );

endmodule

/* iis_assertions.sv */
// Protocol checks on the I2S clocking, the DAC line and rx_valid
// Bound into iis_loopback_top from the testbench
`timescale 1ns/1ns

module iis_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic bclk,
  input logic lrclk,
  input logic bclk_rise,
  input logic bclk_fall,
  input logic frame_start,
  input logic dac_sdata,
  input logic rx_valid
);

  int unsigned lr_fails     = 0;
  int unsigned reset_fails  = 0;
  int unsigned pulse_fails  = 0;
  int unsigned stable_fails = 0;
  int unsigned fail_count;

  assign fail_count = lr_fails + reset_fails + pulse_fails + stable_fails;

  // LRCLK moves only together with a BCLK falling edge
  lrclk_on_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lrclk != $past(lrclk)) |-> bclk_fall)
    else begin
      $error("lrclk changed outside a bclk_fall cycle");
      lr_fails++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!bclk && !lrclk && !rx_valid))
    else begin
      $error("bclk, lrclk or rx_valid active during reset");
      reset_fails++;
    end

  frame_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    frame_start |=> !frame_start)
    else begin
      $error("frame_start wider than one cycle");
      pulse_fails++;
    end

  // Receiver side samples here, so the line must hold
  dac_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_rise |=> $stable(dac_sdata))
    else begin
      $error("dac_sdata changed across a bclk_rise");
      stable_fails++;
    end

endmodule

/* tb_iis_loopback.sv */
// Testbench for the I2S loopback: applies one table row per frame on tx_load and checks
// the codec capture of both slots, the received ADC words and the frame pacing
`timescale 1ns/1ns

module tb_iis_loopback;

  localparam int unsigned DATA_SIZE         = iis_pkg::DEF_DATA_SIZE;
  localparam int unsigned DATA_SIZE_FIR_OUT = iis_pkg::DEF_DATA_SIZE_FIR_OUT;
  localparam int unsigned SLOT_BITS         = iis_pkg::DEF_SLOT_BITS;
  localparam int unsigned BCLK_DIV          = iis_pkg::DEF_BCLK_DIV;

  localparam int FRAME_CYCLES = int'(2 * SLOT_BITS * 2 * BCLK_DIV);  // clk_i cycles per frame
  localparam int RESET_CYCLES = 16;
  localparam int N_FIXED      = 6;
  localparam int N_ROWS       = 12;

  logic                 clk_i;
  logic                 rst_ni;
  iis_pkg::dac_sample_t tx_left;
  iis_pkg::dac_sample_t tx_right;
  iis_pkg::adc_sample_t codec_data_in;
  logic                 tx_load;
  iis_pkg::adc_sample_t rx_left;
  iis_pkg::adc_sample_t rx_right;
  logic                 rx_valid;
  iis_pkg::dac_sample_t codec_data_out;
  logic                 lrclk;

  // Stimulus columns and expected values, one row per frame
  iis_pkg::dac_sample_t row_left   [N_ROWS];
  iis_pkg::dac_sample_t row_right  [N_ROWS];
  iis_pkg::adc_sample_t row_codec  [N_ROWS];
  iis_pkg::dac_sample_t exp_first  [N_ROWS];   // Codec capture of the left slot
  iis_pkg::dac_sample_t exp_second [N_ROWS];   // Codec capture of the right slot
  iis_pkg::adc_sample_t exp_rx     [N_ROWS];   // Same word expected on both rx outputs

  logic [31:0] lfsr_state;
  int          errors      = 0;
  int          checks      = 0;
  int          row_base    = 0;
  int          cycle_cnt   = 0;   // clk_i cycles since reset release
  int          last_load   = 0;
  int          load_pulses = 0;
  int          rx_pulses   = 0;
  logic        load_seen   = 1'b0;
  logic        rx_seen     = 1'b0;

  iis_loopback_top #(
    .DATA_SIZE         (DATA_SIZE),
    .DATA_SIZE_FIR_OUT (DATA_SIZE_FIR_OUT),
    .SLOT_BITS         (SLOT_BITS),
    .BCLK_DIV          (BCLK_DIV)
  ) DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tx_left        (tx_left),
    .tx_right       (tx_right),
    .codec_data_in  (codec_data_in),
    .tx_load        (tx_load),
    .rx_left        (rx_left),
    .rx_right       (rx_right),
    .rx_valid       (rx_valid),
    .codec_data_out (codec_data_out),
    .lrclk          (lrclk)
  );

  bind iis_loopback_top iis_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bclk        (bclk),
    .lrclk       (lrclk),
    .bclk_rise   (bclk_rise),
    .bclk_fall   (bclk_fall),
    .frame_start (frame_start),
    .dac_sdata   (dac_sdata),
    .rx_valid    (rx_valid)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (rst_ni) cycle_cnt <= cycle_cnt + 1;
  end

  // Count rising edges of the two pulse outputs
  always @(negedge clk_i) begin
    if (tx_load && !load_seen) load_pulses <= load_pulses + 1;
    if (rx_valid && !rx_seen) rx_pulses <= rx_pulses + 1;
    load_seen <= tx_load;
    rx_seen   <= rx_valid;
  end

  // Watchdog, sized to the whole table plus some spare frames
  initial begin
    repeat (RESET_CYCLES + (N_ROWS + 3) * FRAME_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d frames", N_ROWS + 3);
    $display("Simulation FAILED");
    $finish;
  end

  // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic random_bits(input int nbits, output logic [31:0] word);
    word = '0;
    for (int i = 0; i < nbits; i++) begin
      word       = {word[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Whole sample lands in the codec, the ADC word comes back on both slots
  task automatic set_row(input int idx, input iis_pkg::dac_sample_t l,
                         input iis_pkg::dac_sample_t r, input iis_pkg::adc_sample_t c);
    row_left[idx]   = l;
    row_right[idx]  = r;
    row_codec[idx]  = c;
    exp_first[idx]  = l;
    exp_second[idx] = r;
    exp_rx[idx]     = c;
  endtask

  task automatic build_table();
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] c;
    set_row(0, 32'hffff_ffff, 32'hffff_ffff, 16'hffff);
    set_row(1, 32'h0000_0000, 32'h0000_0000, 16'h0000);   // Zeros right after ones
    set_row(2, 32'haaaa_aaaa, 32'h5555_5555, 16'haaaa);
    set_row(3, 32'h5555_5555, 32'haaaa_aaaa, 16'h5555);
    set_row(4, 32'h8000_0000, 32'h8000_0000, 16'h8000);   // MSB only
    set_row(5, 32'h0000_0001, 32'h7fff_fffe, 16'h0001);
    for (int i = N_FIXED; i < N_ROWS; i++) begin
      random_bits(32, l);
      random_bits(32, r);
      random_bits(DATA_SIZE, c);
      set_row(i, l, r, c[15:0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Checks that close a row: received words, then the right slot capture
  task automatic finish_row(input int r);
    @(negedge clk_i);
    checks++;
    if (!rx_valid) begin
      errors++;
      $display("Error: rx_valid did not pulse after the frame of row %0d", r);
    end
    check_value("rx_left", 32'(rx_left), 32'(exp_rx[r]));
    check_value("rx_right", 32'(rx_right), 32'(exp_rx[r]));
    repeat (4) @(negedge clk_i);
    check_value("codec_data_out", 32'(codec_data_out), 32'(exp_second[r]));
    $display("row %0d: left %h right %h codec %h, %0d error(s)", r, row_left[r],
             row_right[r], row_codec[r], errors - row_base);
  endtask

  initial begin
    int idle_bad;
    rst_ni        = 1'b0;
    tx_left       = '0;
    tx_right      = '0;
    codec_data_in = '0;
    lfsr_state    = 32'h9767_75fd;
    build_table();
    tx_left  = row_left[0];
    tx_right = row_right[0];
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    @(negedge clk_i);
    check_value("tx_load", 32'(tx_load), 32'h0);
    check_value("rx_valid", 32'(rx_valid), 32'h0);
    check_value("codec_data_out", 32'(codec_data_out), 32'h0);
    idle_bad = 0;
    while (!tx_load) begin
      if (rx_valid || (codec_data_out != '0)) idle_bad++;
      @(negedge clk_i);
    end
    checks++;
    if (idle_bad != 0) begin
      errors++;
      $display("Error: outputs were active in %0d cycles before the first frame", idle_bad);
    end

    for (int k = 0; k <= N_ROWS; k++) begin
      while (!tx_load) @(negedge clk_i);
      check_value("tx_load spacing", 32'(cycle_cnt - last_load), 32'(FRAME_CYCLES));
      check_value("lrclk", 32'(lrclk), 32'h0);   // Frame opens with the left slot
      last_load = cycle_cnt;
      @(posedge clk_i);
      #1;
      // Row k goes out on both lines during this frame, row k+1 waits for the next load
      if (k < N_ROWS) codec_data_in = row_codec[k];
      else codec_data_in = '0;
      if (k + 1 < N_ROWS) begin
        tx_left  = row_left[k + 1];
        tx_right = row_right[k + 1];
      end else begin
        tx_left  = '0;
        tx_right = '0;
      end
      if (k > 0) finish_row(k - 1);
      row_base = errors;
      if (k < N_ROWS) begin
        while (!lrclk) @(negedge clk_i);
        check_value("lrclk rise", 32'(cycle_cnt - last_load), 32'(FRAME_CYCLES / 2));
        repeat (4) @(negedge clk_i);
        check_value("codec_data_out", 32'(codec_data_out), 32'(exp_first[k]));
      end
    end

    repeat (4) @(negedge clk_i);
    check_value("tx_load pulses", 32'(load_pulses), 32'(N_ROWS + 1));
    check_value("rx_valid pulses", 32'(rx_pulses), 32'(N_ROWS + 1));
    checks++;
    if (DUT.u_assertions.fail_count != 0) begin
      errors++;
      $display("Error: %0d protocol assertion failures", DUT.u_assertions.fail_count);
    end
    $display("%0d rows, %0d checks, %0d errors", N_ROWS, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
iis_pkg.sv
iis_clock_gen.sv
iis_transmitter.sv
iis_receiver.sv
iis_dummy_device.sv
iis_loopback_top.sv
iis_assertions.sv
tb_iis_loopback.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_iis_loopback
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Simulation FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
